//--- cell_bank.sv
`timescale 1ns/1ps
`include "cell_buffer_defines.svh"

module cell_bank
    import frame_pkg::*;
#(
    parameter type entry_t = logic [`PIXEL_W-1:0]
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  cell_mask_t wr_mask_i,
    input  crow_addr_t wr_row_i,
    input  entry_t     wr_data_i [`LINE_CNUM],
    input  cell_addr_t rd_cell_i,
    output entry_t     rd_rows_o [`CELL_PNUM]
);

    localparam int CELLS = `LINE_CNUM;
    localparam int ROWS  = `CELL_PNUM;

    // One entry per pixel row of every cell
    entry_t mem [CELLS][ROWS];

    // Several cells may be written in the same cycle, all at one row
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int c = 0; c < CELLS; c++) begin
                for (int r = 0; r < ROWS; r++) begin
                    mem[c][r] <= '0;
                end
            end
        end else begin
            for (int c = 0; c < CELLS; c++) begin
                if (wr_mask_i[c]) begin
                    mem[c][wr_row_i] <= wr_data_i[c];
                end
            end
        end
    end

    // All rows of the addressed cell
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            rd_rows_o[r] = mem[rd_cell_i][r];
        end
    end

endmodule

//--- cell_buffer_assert.sv
`timescale 1ns/1ps
`include "cell_buffer_defines.svh"

module cell_buffer_assert
    import pixel_pkg::*;
    import frame_pkg::*;
(
    input logic        clk,
    input logic        rst_n_i,
    input pgroup_t     pgroup_i,
    input logic        pgroup_wr_en_i,
    input group_addr_t grp_addr_i,
    input crow_addr_t  crow_addr_i,
    input cell_addr_t  cell_addr_i,
    input cell_word_t  cell_data_i
);

    localparam int GCELLS = `GROUP_CNUM;
    localparam int CPIX   = `CELL_PNUM;
    localparam int LAST   = `LINE_CNUM - 1;

    typedef logic [$clog2(`GROUP_PNUM)-1:0] pix_idx_t;

    localparam cell_word_t        ZERO_WORD = '0;
    localparam pixel_t [CPIX-1:0] ZERO_HALO = '0;

    int unsigned fail_count = 0;

    // Inputs and output of the cycle before
    logic        rst_q;
    logic        wr_q;
    group_addr_t grp_q;
    crow_addr_t  row_q;
    pgroup_t     data_q;
    cell_addr_t  cell_q;
    cell_word_t  word_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_q  <= 1'b1;
            wr_q   <= 1'b0;
            grp_q  <= '0;
            row_q  <= '0;
            data_q <= '0;
            cell_q <= '0;
            word_q <= '0;
        end else begin
            rst_q  <= 1'b0;
            wr_q   <= pgroup_wr_en_i;
            grp_q  <= grp_addr_i;
            row_q  <= crow_addr_i;
            data_q <= pgroup_i;
            cell_q <= cell_addr_i;
            word_q <= cell_data_i;
        end
    end

    int        rel;
    logic      int_chk;
    logic      left_chk;
    logic      right_chk;
    cell_row_t int_exp;
    pixel_t    left_exp;
    pixel_t    right_exp;
    cell_row_t int_act;
    pixel_t    left_act;
    pixel_t    right_act;

    // Read cell relative to the first cell of the written group
    always_comb begin
        rel       = int'(cell_addr_i) - GCELLS * int'(grp_q);
        int_chk   = wr_q && (rel >= 0) && (rel < GCELLS);
        // Cells 1 to 3 of the group, then the first cell of the next group
        left_chk  = wr_q && (rel >= 1) && (rel <= GCELLS);
        // Last cell of the previous group, then cells 0 to 2 of the group
        right_chk = wr_q && (rel >= -1) && (rel < GCELLS - 1);

        int_exp   = '0;
        left_exp  = '0;
        right_exp = '0;
        if (int_chk) begin
            int_exp = data_q[pix_idx_t'(rel * CPIX) +: CPIX];
        end
        if (left_chk) begin
            left_exp = data_q[pix_idx_t'(rel * CPIX - 1)];
        end
        if (right_chk) begin
            right_exp = data_q[pix_idx_t'(rel * CPIX + CPIX)];
        end

        int_act   = cell_data_i.interior[row_q];
        left_act  = cell_data_i.left_halo[row_q];
        right_act = cell_data_i.right_halo[row_q];
    end

    a_reset_zero: assert property (
        @(negedge clk) (!rst_n_i || rst_q) |-> cell_data_i == ZERO_WORD
    ) else begin
        $error("[ERROR] cell_data_o expected %h got %h", ZERO_WORD, cell_data_i);
        fail_count++;
    end

    a_interior: assert property (
        @(negedge clk) disable iff (!rst_n_i) int_chk |-> int_act == int_exp
    ) else begin
        $error("[ERROR] cell_data_o.interior[%0d] cell %0d expected %h got %h",
               row_q, cell_addr_i, int_exp, int_act);
        fail_count++;
    end

    a_left_halo: assert property (
        @(negedge clk) disable iff (!rst_n_i) left_chk |-> left_act == left_exp
    ) else begin
        $error("[ERROR] cell_data_o.left_halo[%0d] cell %0d expected %h got %h",
               row_q, cell_addr_i, left_exp, left_act);
        fail_count++;
    end

    a_right_halo: assert property (
        @(negedge clk) disable iff (!rst_n_i) right_chk |-> right_act == right_exp
    ) else begin
        $error("[ERROR] cell_data_o.right_halo[%0d] cell %0d expected %h got %h",
               row_q, cell_addr_i, right_exp, right_act);
        fail_count++;
    end

    // Line ends have no neighbor to borrow from
    a_left_edge: assert property (
        @(negedge clk) (cell_addr_i == '0) |-> cell_data_i.left_halo == ZERO_HALO
    ) else begin
        $error("[ERROR] cell_data_o.left_halo cell 0 expected %h got %h",
               ZERO_HALO, cell_data_i.left_halo);
        fail_count++;
    end

    a_right_edge: assert property (
        @(negedge clk) (cell_addr_i == cell_addr_t'(LAST))
            |-> cell_data_i.right_halo == ZERO_HALO
    ) else begin
        $error("[ERROR] cell_data_o.right_halo cell %0d expected %h got %h",
               LAST, ZERO_HALO, cell_data_i.right_halo);
        fail_count++;
    end

    a_hold: assert property (
        @(negedge clk) disable iff (!rst_n_i)
            (!wr_q && cell_addr_i == cell_q) |-> cell_data_i == word_q
    ) else begin
        $error("[ERROR] cell_data_o cell %0d expected %h got %h",
               cell_addr_i, word_q, cell_data_i);
        fail_count++;
    end

endmodule

bind cell_buffer_top cell_buffer_assert assert_i (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .pgroup_i       (pgroup_i),
    .pgroup_wr_en_i (pgroup_wr_en_i),
    .grp_addr_i     (grp_addr_i),
    .crow_addr_i    (crow_addr_i),
    .cell_addr_i    (cell_addr_i),
    .cell_data_i    (cell_data_o)
);

//--- cell_buffer_defines.svh
`ifndef CELL_BUFFER_DEFINES_SVH
`define CELL_BUFFER_DEFINES_SVH

// Bits per pixel
`define PIXEL_W     8

// Pixels per cell side, cells are square
`define CELL_PNUM   8

// Cells carried by one pixel group
`define GROUP_CNUM  4

// Cells per line, a multiple of GROUP_CNUM
`define LINE_CNUM   8

// Pixels per group
`define GROUP_PNUM  (`GROUP_CNUM * `CELL_PNUM)

`endif

//--- cell_buffer_tb.sv
`timescale 1ns/1ps
`include "cell_buffer_defines.svh"

module cell_buffer_tb
    import pixel_pkg::*;
    import frame_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int RST_CYCLES    = 8;
    localparam int FILL_CYCLES   = GROUP_NUM * `CELL_PNUM;
    localparam int SWEEP_CYCLES  = 2 * `LINE_CNUM;
    localparam int OVERWRITE_NUM = 48;
    localparam int TAIL_CYCLES   = 4;
    localparam int STIM_CYCLES   = RST_CYCLES + FILL_CYCLES + SWEEP_CYCLES
                                 + 2 * OVERWRITE_NUM + TAIL_CYCLES;
    // Half again as long as the stimulus
    localparam int WATCHDOG_NS   = STIM_CYCLES * CLK_PERIOD * 3 / 2;

    logic        clk;
    logic        rst_n_i;
    pgroup_t     pgroup_i;
    logic        pgroup_wr_en_i;
    group_addr_t grp_addr_i;
    crow_addr_t  crow_addr_i;
    cell_addr_t  cell_addr_i;
    cell_word_t  cell_data_o;

    logic [31:0] lcg_state = 32'h2080_32cb;

    cell_buffer_top dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pgroup_i       (pgroup_i),
        .pgroup_wr_en_i (pgroup_wr_en_i),
        .grp_addr_i     (grp_addr_i),
        .crow_addr_i    (crow_addr_i),
        .cell_addr_i    (cell_addr_i),
        .cell_data_o    (cell_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits only, the low ones cycle quickly
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    function automatic pgroup_t random_group();
        pgroup_t d;
        d = '0;
        for (int w = 0; w < `GROUP_PNUM / 4; w++) begin
            d = pgroup_t'({d, next_rand()});
        end
        return d;
    endfunction

    // Pick 0 is the cell left of the group, pick 5 the cell right of it
    function automatic cell_addr_t near_cell(input group_addr_t g, input int pick);
        int c;
        c = `GROUP_CNUM * int'(g) - 1 + pick;
        if (c < 0 || c >= `LINE_CNUM) begin
            c = `GROUP_CNUM * int'(g) + pick % `GROUP_CNUM;
        end
        return cell_addr_t'(c);
    endfunction

    task automatic write_group(input group_addr_t g, input crow_addr_t r,
                               input pgroup_t d, input cell_addr_t c);
        @(posedge clk);
        pgroup_wr_en_i <= 1'b1;
        grp_addr_i     <= g;
        crow_addr_i    <= r;
        pgroup_i       <= d;
        cell_addr_i    <= c;
    endtask

    task automatic idle_cycle(input cell_addr_t c);
        @(posedge clk);
        pgroup_wr_en_i <= 1'b0;
        cell_addr_i    <= c;
    endtask

    task automatic stop_with_failure(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    initial begin
        wait (dut.assert_i.fail_count != 0);
        stop_with_failure("an assertion on the DUT outputs failed");
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure($sformatf("watchdog expired after %0d ns", WATCHDOG_NS));
    end

    initial begin
        group_addr_t g;
        crow_addr_t  r;

        rst_n_i        = 1'b0;
        pgroup_i       = '0;
        pgroup_wr_en_i = 1'b0;
        grp_addr_i     = '0;
        crow_addr_i    = '0;
        cell_addr_i    = '0;

        // Read address wanders while the stores are held clear
        repeat (RST_CYCLES) begin
            @(posedge clk);
            cell_addr_i <= cell_addr_t'(rand_below(`LINE_CNUM));
        end
        rst_n_i <= 1'b1;

        // Fill every row of every group
        for (int gi = 0; gi < GROUP_NUM; gi++) begin
            for (int ri = 0; ri < `CELL_PNUM; ri++) begin
                write_group(group_addr_t'(gi), crow_addr_t'(ri), random_group(),
                            cell_addr_t'(rand_below(`LINE_CNUM)));
            end
        end

        // Each cell twice in a row so the output must hold
        for (int ci = 0; ci < `LINE_CNUM; ci++) begin
            idle_cycle(cell_addr_t'(ci));
            idle_cycle(cell_addr_t'(ci));
        end

        for (int i = 0; i < OVERWRITE_NUM; i++) begin
            g = group_addr_t'(rand_below(GROUP_NUM));
            r = crow_addr_t'(rand_below(`CELL_PNUM));
            write_group(g, r, random_group(), cell_addr_i);
            idle_cycle(near_cell(g, rand_below(`GROUP_CNUM + 2)));
        end

        repeat (TAIL_CYCLES) begin
            idle_cycle(cell_addr_i);
        end

        if (dut.assert_i.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("assertion failures were counted by the end of the run");
        end
    end

endmodule

//--- cell_buffer_top.sv
`timescale 1ns/1ps
`include "cell_buffer_defines.svh"

module cell_buffer_top
    import pixel_pkg::*;
    import frame_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  pgroup_t     pgroup_i,
    input  logic        pgroup_wr_en_i,
    input  group_addr_t grp_addr_i,
    input  crow_addr_t  crow_addr_i,
    input  cell_addr_t  cell_addr_i,
    output cell_word_t  cell_data_o
);

    cell_mask_t int_wr;
    cell_mask_t left_wr;
    cell_mask_t right_wr;

    cell_row_t  int_data   [`LINE_CNUM];
    pixel_t     left_data  [`LINE_CNUM];
    pixel_t     right_data [`LINE_CNUM];

    cell_row_t  int_rows   [`CELL_PNUM];
    pixel_t     left_rows  [`CELL_PNUM];
    pixel_t     right_rows [`CELL_PNUM];

    group_router router (
        .pgroup_wr_en_i (pgroup_wr_en_i),
        .grp_addr_i     (grp_addr_i),
        .pgroup_i       (pgroup_i),
        .int_wr_o       (int_wr),
        .left_wr_o      (left_wr),
        .right_wr_o     (right_wr),
        .int_data_o     (int_data),
        .left_data_o    (left_data),
        .right_data_o   (right_data)
    );

    cell_bank #(.entry_t(cell_row_t)) int_bank (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_mask_i (int_wr),
        .wr_row_i  (crow_addr_i),
        .wr_data_i (int_data),
        .rd_cell_i (cell_addr_i),
        .rd_rows_o (int_rows)
    );

    cell_bank #(.entry_t(pixel_t)) left_bank (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_mask_i (left_wr),
        .wr_row_i  (crow_addr_i),
        .wr_data_i (left_data),
        .rd_cell_i (cell_addr_i),
        .rd_rows_o (left_rows)
    );

    cell_bank #(.entry_t(pixel_t)) right_bank (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_mask_i (right_wr),
        .wr_row_i  (crow_addr_i),
        .wr_data_i (right_data),
        .rd_cell_i (cell_addr_i),
        .rd_rows_o (right_rows)
    );

    // Row r of each store lands in slot r of its field
    for (genvar r = 0; r < `CELL_PNUM; r++) begin : g_pack
        assign cell_data_o.interior[r]   = int_rows[r];
        assign cell_data_o.left_halo[r]  = left_rows[r];
        assign cell_data_o.right_halo[r] = right_rows[r];
    end

endmodule

//--- filelist.f
+incdir+.
pixel_pkg.sv
frame_pkg.sv
cell_bank.sv
group_router.sv
cell_buffer_top.sv
cell_buffer_assert.sv
cell_buffer_tb.sv

//--- frame_pkg.sv
`include "cell_buffer_defines.svh"

package frame_pkg;

    // Groups per line
    localparam int GROUP_NUM = `LINE_CNUM / `GROUP_CNUM;

    // Keep at least one bit when the line holds a single group
    localparam int GROUP_AW = (GROUP_NUM > 1) ? $clog2(GROUP_NUM) : 1;

    typedef logic [$clog2(`LINE_CNUM)-1:0] cell_addr_t;
    typedef logic [GROUP_AW-1:0]           group_addr_t;
    typedef logic [$clog2(`CELL_PNUM)-1:0] crow_addr_t;

    // One bit per cell of the line
    typedef logic [`LINE_CNUM-1:0] cell_mask_t;

endpackage

//--- group_router.sv
`timescale 1ns/1ps
`include "cell_buffer_defines.svh"

module group_router
    import pixel_pkg::*;
    import frame_pkg::*;
(
    input  logic        pgroup_wr_en_i,
    input  group_addr_t grp_addr_i,
    input  pgroup_t     pgroup_i,
    output cell_mask_t  int_wr_o,
    output cell_mask_t  left_wr_o,
    output cell_mask_t  right_wr_o,
    output cell_row_t   int_data_o   [`LINE_CNUM],
    output pixel_t      left_data_o  [`LINE_CNUM],
    output pixel_t      right_data_o [`LINE_CNUM]
);

    localparam int CELLS  = `LINE_CNUM;
    localparam int GCELLS = `GROUP_CNUM;
    localparam int CPIX   = `CELL_PNUM;
    localparam int GPIX   = `GROUP_PNUM;

    // One-hot group select, qualified by the strobe
    logic [GROUP_NUM-1:0] grp_hit;

    for (genvar g = 0; g < GROUP_NUM; g++) begin : g_grp
        assign grp_hit[g] = pgroup_wr_en_i && (grp_addr_i == group_addr_t'(g));
    end

    // Interior rows
    // Cell k of the group takes pixels 8k to 8k+7
    for (genvar c = 0; c < CELLS; c++) begin : g_int
        localparam int G = c / GCELLS;
        localparam int K = c % GCELLS;

        assign int_wr_o[c]   = grp_hit[G];
        assign int_data_o[c] = pgroup_i[K*CPIX +: CPIX];
    end

    // Left halo
    for (genvar c = 0; c < CELLS; c++) begin : g_left
        localparam int G = c / GCELLS;
        localparam int K = c % GCELLS;

        if (K != 0) begin : g_inner
            // Last pixel of the cell to the left, same group
            assign left_wr_o[c]   = grp_hit[G];
            assign left_data_o[c] = pgroup_i[K*CPIX-1];
        end else if (G != 0) begin : g_cross
            // First cell of a group borders the previous group
            assign left_wr_o[c]   = grp_hit[G-1];
            assign left_data_o[c] = pgroup_i[GPIX-1];
        end else begin : g_edge
            // Nothing left of the line
            assign left_wr_o[c]   = 1'b0;
            assign left_data_o[c] = '0;
        end
    end

    // Right halo
    for (genvar c = 0; c < CELLS; c++) begin : g_right
        localparam int G = c / GCELLS;
        localparam int K = c % GCELLS;

        if (K != GCELLS-1) begin : g_inner
            // First pixel of the cell to the right, same group
            assign right_wr_o[c]   = grp_hit[G];
            assign right_data_o[c] = pgroup_i[K*CPIX+CPIX];
        end else if (G != GROUP_NUM-1) begin : g_cross
            // Last cell of a group borders the next group
            assign right_wr_o[c]   = grp_hit[G+1];
            assign right_data_o[c] = pgroup_i[0];
        end else begin : g_edge
            // Nothing right of the line
            assign right_wr_o[c]   = 1'b0;
            assign right_data_o[c] = '0;
        end
    end

endmodule

//--- pixel_pkg.sv
`include "cell_buffer_defines.svh"

package pixel_pkg;

    typedef logic [`PIXEL_W-1:0] pixel_t;

    // Pixel 0 sits in the lowest byte
    typedef pixel_t [`CELL_PNUM-1:0] cell_row_t;

    // One input beat covering GROUP_CNUM adjacent cells
    typedef pixel_t [`GROUP_PNUM-1:0] pgroup_t;

    // Read result of one cell
    // Interior in the upper bits, right halo in the lowest
    typedef struct packed {
        cell_row_t [`CELL_PNUM-1:0] interior;
        pixel_t    [`CELL_PNUM-1:0] left_halo;
        pixel_t    [`CELL_PNUM-1:0] right_halo;
    } cell_word_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module cell_buffer_tb \
    -j 0

# Keep the run going past the first assertion so the testbench reports it
status=0
output="$(./obj_dir/Vcell_buffer_tb +verilator+error+limit+100 2>&1)" || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed (exit status $status)"
    exit 1
fi
